//--- flist.f
+incdir+verilog
verilog/icache_addr_pkg.sv
verilog/icache_ctrl_pkg.sv
verilog/icache_tag_array.sv
verilog/icache_data_array.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
tests/icache_checker.sv
tests/icache_tb.sv

//--- run.sh
#!/bin/sh
# build the instruction cache testbench with Verilator and run it from the project root
# the result is taken from the simulation output only, nothing is written to a log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f flist.f --top-module icache_tb -Mdir obj_dir &&
./obj_dir/Vicache_tb | tee /dev/stderr | grep -qx "all tests passed" &&
echo "simulation ok" ||
{ echo "simulation not ok" >&2; exit 1; }

//--- tests/icache_golden.txt
# op name addr expected_inst expected_hit  (op F fetch, I invalidate, X flush)
# addr and inst in hex, hit 1 for a hit and 0 for a miss, I and X ignore the last two
F cold_a_w0 00001000 5a5a1000 0
F hit_a_w1 00001004 5a5a1004 1
F hit_a_w2 00001008 5a5a1008 1
F hit_a_w3 0000100c 5a5a100c 1
F hit_a_w0 00001000 5a5a1000 1
F fill_b0 00002100 5a5a2100 0
F fill_b1 00002500 5a5a2500 0
F fill_b2 00002900 5a5a2900 0
F fill_b3 00002d00 5a5a2d00 0
F fill_b4_evict 00003100 5a5a3100 0
F refetch_b0 00002104 5a5a2104 0
F keep_b2 00002908 5a5a2908 1
F keep_b3 00002d0c 5a5a2d0c 1
F keep_b4 00003100 5a5a3100 1
F fill_c0 00004200 5a5a4200 0
F fill_c1 00004600 5a5a4600 0
I snoop_c0 00004208 00000000 0
F refetch_c0 00004204 5a5a4204 0
F keep_c1 00004604 5a5a4604 1
X flush_all 00000000 00000000 0
F flushed_a 00001000 5a5a1000 0
F flushed_b4 00003100 5a5a3100 0
F flushed_c1 00004600 5a5a4600 0
F refill_a 0000100c 5a5a100c 1
F refill_c1 00004600 5a5a4600 1

//--- tests/icache_tb.sv
`include "icache_params.svh"

module icache_tb;
	import icache_addr_pkg::*;

	logic clk;
	logic rst;
	logic fetch_req_valid;
	logic [`ICACHE_ADDR_W-1:0] fetch_req_addr;
	logic fetch_req_ready;
	logic fetch_rsp_valid;
	logic [31:0] fetch_rsp_inst;
	logic fetch_rsp_ready;
	logic mem_req_valid;
	logic [`ICACHE_ADDR_W-1:0] mem_req_addr;
	logic mem_req_ready;
	logic mem_rsp_valid;
	line_t mem_rsp_line;
	logic mem_rsp_ready;
	logic inv_valid;
	logic [`ICACHE_ADDR_W-1:0] inv_addr;
	logic flush;

	// expected result of the fetch being driven
	logic [127:0] exp_name;
	logic [31:0] exp_inst;
	logic exp_hit;
	int pass_count;
	int fail_count;

	// golden operations, one entry per line
	logic [7:0] op_list [$];
	logic [127:0] name_list [$];
	logic [31:0] addr_list [$];
	logic [31:0] inst_list [$];
	logic hit_list [$];
	int n_fetch;
	logic loaded;
	logic [31:0] lfsr_q;

	icache_top UUT (.*);

	icache_checker chk (.*);

	// galois form, taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// one step per bit taken, first bit ends up as msb
	function automatic int random_bits(input int count);
		int v;
		v = 0;
		for (int i = 0; i < count; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			v = (v << 1) | int'(lfsr_q[0]);
		end
		return v;
	endfunction

	// word k holds its own byte address xor a fixed pattern
	function automatic line_t line_for(input logic [31:0] base);
		line_t line;
		for (int k = 0; k < 4; k++) begin
			line[32 * k +: 32] = (base + 32'(4 * k)) ^ 32'h5a5a0000;
		end
		return line;
	endfunction

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic load_golden(output logic ok);
		int fd;
		int fields;
		int hit_val;
		string text;
		logic [7:0] op;
		logic [127:0] name;
		logic [31:0] addr;
		logic [31:0] inst;
		ok = 1'b1;
		n_fetch = 0;
		fd = $fopen("tests/icache_golden.txt", "r");
		if (fd == 0) begin
			$display("cannot open tests/icache_golden.txt");
			ok = 1'b0;
		end else begin
			while (!$feof(fd)) begin
				text = "";
				void'($fgets(text, fd));
				// skip comments and blank lines
				if (text.len() > 1 && text[0] != "#") begin
					fields = $sscanf(text, "%s %s %h %h %d", op, name, addr, inst, hit_val);
					if (fields != 5 || !(op == "F" || op == "I" || op == "X")) begin
						$display("unreadable golden line: %s", text);
						ok = 1'b0;
					end else begin
						op_list.push_back(op);
						name_list.push_back(name);
						addr_list.push_back(addr);
						inst_list.push_back(inst);
						hit_list.push_back(hit_val != 0);
						if (op == "F") begin
							n_fetch++;
						end
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic fetch_one(input logic [127:0] name, input logic [31:0] addr,
			input logic [31:0] inst, input logic hit);
		int hold;
		int held;
		logic done;
		exp_name = name;
		exp_inst = inst;
		exp_hit = hit;
		// stall edges for this response, 0 to 3
		hold = random_bits(2);
		held = 0;
		done = 1'b0;
		fetch_rsp_ready = (hold == 0);
		fetch_req_valid = 1'b1;
		fetch_req_addr = addr;
		// ready seen high at an edge means taken there
		do begin
			@(posedge clk);
		end while (!fetch_req_ready);
		// request stays up so an early second accept would show
		while (!done) begin
			@(posedge clk);
			if (fetch_rsp_valid && fetch_rsp_ready) begin
				done = 1'b1;
			end else if (fetch_rsp_valid) begin
				held++;
			end
			#1;
			if (held >= hold) begin
				fetch_rsp_ready = 1'b1;
			end
		end
		fetch_req_valid = 1'b0;
	endtask

	// one-cycle snoop
	task automatic snoop_line(input logic [31:0] addr);
		inv_addr = addr;
		inv_valid = 1'b1;
		@(posedge clk);
		#1;
		inv_valid = 1'b0;
	endtask

	task automatic flush_cache();
		flush = 1'b1;
		@(posedge clk);
		#1;
		flush = 1'b0;
	endtask

	task automatic run_ops();
		for (int i = 0; i < op_list.size(); i++) begin
			case (op_list[i])
				"F": fetch_one(name_list[i], addr_list[i], inst_list[i], hit_list[i]);
				"I": snoop_line(addr_list[i]);
				// X, the last letter load accepts
				default: flush_cache();
			endcase
		end
	endtask

	task automatic report_and_finish();
		$display("%0d fetch checks: %0d passed, %0d failed", n_fetch, pass_count, fail_count);
		if (pass_count + fail_count != n_fetch) begin
			$display("only %0d of %0d fetches completed", pass_count + fail_count, n_fetch);
		end
		if (fail_count == 0 && pass_count == n_fetch) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	endtask

	// memory side, random gaps before ready and before the line
	initial begin : memory_model
		logic [31:0] line_addr;
		int gap;
		forever begin
			@(posedge clk);
			if (mem_req_valid === 1'b1) begin
				line_addr = mem_req_addr;
				gap = random_bits(2);
				#1;
				repeat (gap) begin
					@(posedge clk);
					#1;
				end
				mem_req_ready = 1'b1;
				@(posedge clk);
				#1;
				mem_req_ready = 1'b0;
				gap = random_bits(2);
				repeat (gap) begin
					@(posedge clk);
					#1;
				end
				mem_rsp_line = line_for(line_addr);
				mem_rsp_valid = 1'b1;
				do begin
					@(posedge clk);
				end while (!mem_rsp_ready);
				#1;
				mem_rsp_valid = 1'b0;
				mem_rsp_line = '0;
			end
		end
	end

	// budget of 40 cycles per golden line plus slack
	initial begin : watchdog
		wait (loaded === 1'b1);
		repeat (40 * op_list.size() + 100) @(posedge clk);
		$display("watchdog expired after %0d cycles", 40 * op_list.size() + 100);
		$display("tests failed");
		$finish;
	end

	initial begin
		logic ok;
		rst = 1'b1;
		fetch_req_valid = 1'b0;
		fetch_req_addr = '0;
		fetch_rsp_ready = 1'b1;
		mem_req_ready = 1'b0;
		mem_rsp_valid = 1'b0;
		mem_rsp_line = '0;
		inv_valid = 1'b0;
		inv_addr = '0;
		flush = 1'b0;
		exp_name = '0;
		exp_inst = '0;
		exp_hit = 1'b0;
		loaded = 1'b0;
		lfsr_q = 32'hed44;
		load_golden(ok);
		loaded = 1'b1;
		if (!ok) begin
			$display("golden file could not be used");
			$display("tests failed");
			$finish;
		end else begin
			// reset held for 3 edges
			repeat (3) @(posedge clk);
			#1;
			rst = 1'b0;
			run_ops();
			repeat (3) @(posedge clk);
			report_and_finish();
		end
	end

endmodule

//--- tests/icache_checker.sv
`include "icache_params.svh"

module icache_checker (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      fetch_req_valid,
	input  logic [`ICACHE_ADDR_W-1:0] fetch_req_addr,
	input  logic                      fetch_req_ready,
	input  logic                      fetch_rsp_valid,
	input  logic [31:0]               fetch_rsp_inst,
	input  logic                      fetch_rsp_ready,
	input  logic                      mem_req_valid,
	input  logic [`ICACHE_ADDR_W-1:0] mem_req_addr,
	input  logic                      mem_req_ready,
	input  logic                      mem_rsp_valid,
	input  logic                      mem_rsp_ready,
	input  logic [127:0]              exp_name,
	input  logic [31:0]               exp_inst,
	input  logic                      exp_hit,
	output int                        pass_count,
	output int                        fail_count
);
	// cycle count, edges since reset release
	int cyc;
	// fetch in flight and what it should return
	logic busy;
	logic bad;
	logic [127:0] cur_name;
	logic [31:0] cur_inst;
	logic cur_hit;
	logic [`ICACHE_ADDR_W-1:0] line_addr;
	int mem_reqs;
	int acc_cyc;
	int rise_cyc;
	logic rise_seen;
	// response seen stalled at the last edge
	logic held_prev;
	logic [31:0] held_inst;
	// refill request taken, line not yet returned
	logic refill_open;

	// outside a fetch an error goes straight to the count
	task automatic flag_error();
		if (busy) begin
			bad = 1'b1;
		end else begin
			fail_count++;
		end
	endtask

	task automatic finish_test();
		logic was_hit;
		int rise_gap;
		// a hit never goes to memory
		was_hit = (mem_reqs == 0);
		rise_gap = rise_cyc - acc_cyc;
		if (fetch_rsp_inst !== cur_inst) begin
			$display("MISMATCH %0s inst expected %08h actual %08h",
				cur_name, cur_inst, fetch_rsp_inst);
			bad = 1'b1;
		end
		if (was_hit !== cur_hit) begin
			$display("MISMATCH %0s hit expected %0d actual %0d", cur_name, cur_hit, was_hit);
			bad = 1'b1;
		end
		if (!was_hit && mem_reqs != 1) begin
			$display("%0s made %0d memory requests for a single miss", cur_name, mem_reqs);
			bad = 1'b1;
		end
		// valid up two edges after acceptance
		if (was_hit && rise_gap != 2) begin
			$display("MISMATCH %0s hit latency expected 2 actual %0d", cur_name, rise_gap);
			bad = 1'b1;
		end
		if (bad) begin
			fail_count++;
			$display("FAIL %0s", cur_name);
		end else begin
			pass_count++;
			$display("ok   %0s", cur_name);
		end
		busy = 1'b0;
	endtask

	// everything sampled at the edge, tb drives 1 unit later
	always @(posedge clk) begin
		if (rst) begin
			cyc = 0;
			busy = 1'b0;
			bad = 1'b0;
			held_prev = 1'b0;
			refill_open = 1'b0;
			pass_count = 0;
			fail_count = 0;
		end else begin
			cyc++;
			// stalled response keeps valid and data
			if (held_prev && (!fetch_rsp_valid || fetch_rsp_inst !== held_inst)) begin
				$display("%0s: response changed while the fetch side stalled", cur_name);
				flag_error();
			end
			held_prev = fetch_rsp_valid && !fetch_rsp_ready;
			held_inst = fetch_rsp_inst;
			// no new fetch taken while a response waits
			if (fetch_rsp_valid && fetch_req_ready) begin
				$display("fetch request port open while a response is pending");
				flag_error();
			end
			if (fetch_req_valid && fetch_req_ready) begin
				if (busy) begin
					$display("%0s: new fetch accepted before it finished", cur_name);
					flag_error();
				end
				busy = 1'b1;
				bad = 1'b0;
				cur_name = exp_name;
				cur_inst = exp_inst;
				cur_hit = exp_hit;
				// 16-byte lines
				line_addr = fetch_req_addr & ~32'hf;
				mem_reqs = 0;
				acc_cyc = cyc;
				rise_seen = 1'b0;
			end
			// response port only open for an accepted refill
			if (mem_rsp_ready && !refill_open) begin
				$display("memory response port ready with no refill outstanding");
				flag_error();
			end
			if (mem_rsp_valid && mem_rsp_ready) begin
				refill_open = 1'b0;
			end
			if (mem_req_valid && mem_req_ready) begin
				mem_reqs++;
				refill_open = 1'b1;
				if (mem_req_addr !== line_addr) begin
					$display("MISMATCH %0s refill address expected %08h actual %08h",
						cur_name, line_addr, mem_req_addr);
					flag_error();
				end
			end
			if (busy && fetch_rsp_valid && !rise_seen) begin
				rise_seen = 1'b1;
				// valid was set at the previous edge
				rise_cyc = cyc - 1;
			end
			if (fetch_rsp_valid && fetch_rsp_ready) begin
				if (busy) begin
					finish_test();
				end else begin
					$display("fetch response with no fetch outstanding");
					flag_error();
				end
			end
		end
	end

endmodule

//--- verilog/icache_top.sv
`include "icache_params.svh"

module icache_top (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      fetch_req_valid,
	input  logic [`ICACHE_ADDR_W-1:0] fetch_req_addr,
	output logic                      fetch_req_ready,
	output logic                      fetch_rsp_valid,
	output logic [31:0]               fetch_rsp_inst,
	input  logic                      fetch_rsp_ready,
	output logic                      mem_req_valid,
	output logic [`ICACHE_ADDR_W-1:0] mem_req_addr,
	input  logic                      mem_req_ready,
	input  logic                      mem_rsp_valid,
	input  icache_addr_pkg::line_t    mem_rsp_line,
	output logic                      mem_rsp_ready,
	input  logic                      inv_valid,
	input  logic [`ICACHE_ADDR_W-1:0] inv_addr,
	input  logic                      flush
);
	import icache_addr_pkg::*;
	import icache_ctrl_pkg::*;

	// controller to tag array
	logic [`ICACHE_ADDR_W-1:0] lookup_addr;
	way_t hit_way;
	logic fill_en;
	way_t fill_way;
	logic [`ICACHE_ADDR_W-1:0] fill_addr;

	// controller to data array
	logic rd_en;
	way_t rd_way;
	index_t rd_index;
	word_sel_t rd_word;
	logic [31:0] rd_inst;
	logic wr_en;
	way_t wr_way;
	index_t wr_index;
	line_t wr_line;

	icache_ctrl u_ctrl (
		.clk(clk),
		.rst(rst),
		.fetch_req_valid(fetch_req_valid),
		.fetch_req_addr(fetch_req_addr),
		.fetch_req_ready(fetch_req_ready),
		.fetch_rsp_valid(fetch_rsp_valid),
		.fetch_rsp_inst(fetch_rsp_inst),
		.fetch_rsp_ready(fetch_rsp_ready),
		.mem_req_valid(mem_req_valid),
		.mem_req_addr(mem_req_addr),
		.mem_req_ready(mem_req_ready),
		.mem_rsp_valid(mem_rsp_valid),
		.mem_rsp_line(mem_rsp_line),
		.mem_rsp_ready(mem_rsp_ready),
		.flush(flush),
		.lookup_addr(lookup_addr),
		.hit_way(hit_way),
		.fill_en(fill_en),
		.fill_way(fill_way),
		.fill_addr(fill_addr),
		.rd_en(rd_en),
		.rd_way(rd_way),
		.rd_index(rd_index),
		.rd_word(rd_word),
		.rd_inst(rd_inst),
		.wr_en(wr_en),
		.wr_way(wr_way),
		.wr_index(wr_index),
		.wr_line(wr_line)
	);

	// snoop and flush go straight to the tags
	icache_tag_array u_tags (
		.clk(clk),
		.rst(rst),
		.lookup_addr(lookup_addr),
		.fill_en(fill_en),
		.fill_way(fill_way),
		.fill_addr(fill_addr),
		.inv_valid(inv_valid),
		.inv_addr(inv_addr),
		.flush(flush),
		.hit_way(hit_way)
	);

	icache_data_array u_data (
		.clk(clk),
		.rd_en(rd_en),
		.rd_way(rd_way),
		.rd_index(rd_index),
		.rd_word(rd_word),
		.wr_en(wr_en),
		.wr_way(wr_way),
		.wr_index(wr_index),
		.wr_line(wr_line),
		.rd_inst(rd_inst)
	);

endmodule

//--- verilog/icache_ctrl.sv
`include "icache_params.svh"

module icache_ctrl (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       fetch_req_valid,
	input  logic [`ICACHE_ADDR_W-1:0]  fetch_req_addr,
	output logic                       fetch_req_ready,
	output logic                       fetch_rsp_valid,
	output logic [31:0]                fetch_rsp_inst,
	input  logic                       fetch_rsp_ready,
	output logic                       mem_req_valid,
	output logic [`ICACHE_ADDR_W-1:0]  mem_req_addr,
	input  logic                       mem_req_ready,
	input  logic                       mem_rsp_valid,
	input  icache_addr_pkg::line_t     mem_rsp_line,
	output logic                       mem_rsp_ready,
	input  logic                       flush,
	output logic [`ICACHE_ADDR_W-1:0]  lookup_addr,
	input  icache_ctrl_pkg::way_t      hit_way,
	output logic                       fill_en,
	output icache_ctrl_pkg::way_t      fill_way,
	output logic [`ICACHE_ADDR_W-1:0]  fill_addr,
	output logic                       rd_en,
	output icache_ctrl_pkg::way_t      rd_way,
	output icache_addr_pkg::index_t    rd_index,
	output icache_addr_pkg::word_sel_t rd_word,
	input  logic [31:0]                rd_inst,
	output logic                       wr_en,
	output icache_ctrl_pkg::way_t      wr_way,
	output icache_addr_pkg::index_t    wr_index,
	output icache_addr_pkg::line_t     wr_line
);
	import icache_addr_pkg::*;
	import icache_ctrl_pkg::*;

	ctrl_state_e state_q;
	ctrl_state_e state_d;

	// accepted fetch address
	logic [`ICACHE_ADDR_W-1:0] addr_q;
	way_t victim_q;
	// data array output valid this cycle
	logic rd_pend_q;
	logic rsp_valid_q;
	logic [31:0] rsp_inst_q;

	logic req_fire;
	logic lookup_hit;
	logic refill_beat;
	logic rsp_fire;

	// flush has priority over a new fetch
	assign fetch_req_ready = (state_q == ST_IDLE) && !flush;
	assign req_fire = fetch_req_valid && fetch_req_ready;
	assign lookup_hit = (state_q == ST_LOOKUP) && |hit_way;
	assign refill_beat = mem_rsp_valid && mem_rsp_ready;
	assign rsp_fire = rsp_valid_q && fetch_rsp_ready;

	assign fetch_rsp_valid = rsp_valid_q;
	assign fetch_rsp_inst = rsp_inst_q;

	// line-aligned refill request
	assign mem_req_valid = (state_q == ST_REFILL_REQ);
	assign mem_req_addr = {addr_q[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};
	assign mem_rsp_ready = (state_q == ST_REFILL_WAIT);

	assign lookup_addr = addr_q;

	// hit read during lookup
	assign rd_en = lookup_hit;
	assign rd_way = hit_way;
	assign rd_index = addr_index(addr_q);
	assign rd_word = addr_word(addr_q);

	// fill goes to tags and data on the same beat
	assign fill_en = refill_beat;
	assign fill_way = victim_q;
	assign fill_addr = addr_q;
	assign wr_en = refill_beat;
	assign wr_way = victim_q;
	assign wr_index = addr_index(addr_q);
	assign wr_line = mem_rsp_line;

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (req_fire) begin
					state_d = ST_LOOKUP;
				end
			end
			ST_LOOKUP: begin
				state_d = lookup_hit ? ST_RESP : ST_REFILL_REQ;
			end
			ST_REFILL_REQ: begin
				if (mem_req_ready) begin
					state_d = ST_REFILL_WAIT;
				end
			end
			ST_REFILL_WAIT: begin
				if (refill_beat) begin
					state_d = ST_RESP;
				end
			end
			ST_RESP: begin
				// held here under back-pressure
				if (rsp_fire) begin
					state_d = ST_IDLE;
				end
			end
			default: state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= ST_IDLE;
			victim_q <= way_t'(1);
			rd_pend_q <= 1'b0;
			rsp_valid_q <= 1'b0;
		end else begin
			state_q <= state_d;
			// one step per refill
			if (refill_beat) begin
				victim_q <= rotate_way(victim_q);
			end
			rd_pend_q <= rd_en;
			if (rd_pend_q || refill_beat) begin
				rsp_valid_q <= 1'b1;
			end else if (rsp_fire) begin
				rsp_valid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (req_fire) begin
			addr_q <= fetch_req_addr;
		end
		// hit word from the array, miss word straight off the refill beat
		if (rd_pend_q) begin
			rsp_inst_q <= rd_inst;
		end else if (refill_beat) begin
			rsp_inst_q <= line_word(mem_rsp_line, addr_word(addr_q));
		end
	end

	a_mem_req_hold: assert property (@(posedge clk) disable iff (rst)
		mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr))
		else $error("icache ctrl: mem request dropped before ready");

endmodule

//--- verilog/icache_data_array.sv
`include "icache_params.svh"

module icache_data_array (
	input  logic                      clk,
	input  logic                      rd_en,
	input  icache_ctrl_pkg::way_t     rd_way,
	input  icache_addr_pkg::index_t   rd_index,
	input  icache_addr_pkg::word_sel_t rd_word,
	input  logic                      wr_en,
	input  icache_ctrl_pkg::way_t     wr_way,
	input  icache_addr_pkg::index_t   wr_index,
	input  icache_addr_pkg::line_t    wr_line,
	output logic [31:0]               rd_inst
);
	import icache_addr_pkg::*;

	// behavioral line storage, one bank per way
	line_t mem_q [`ICACHE_WAYS][`ICACHE_SETS];

	line_t rd_line;

	// one-hot way mux
	always_comb begin
		rd_line = '0;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (rd_way[w]) begin
				rd_line = rd_line | mem_q[w][rd_index];
			end
		end
	end

	// registered read, word picked before the flop
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_inst <= line_word(rd_line, rd_word);
		end
	end

	// whole line per write
	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				if (wr_way[w]) begin
					mem_q[w][wr_index] <= wr_line;
				end
			end
		end
	end

	// controller keeps lookup reads and refill writes in separate states
	a_no_rw_clash: assert property (@(posedge clk)
		!(rd_en && wr_en && |(rd_way & wr_way) && (rd_index == wr_index)))
		else $error("icache data array: read and write hit the same line");

endmodule

//--- verilog/icache_tag_array.sv
`include "icache_params.svh"

module icache_tag_array (
	input  logic                      clk,
	input  logic                      rst,
	input  logic [`ICACHE_ADDR_W-1:0] lookup_addr,
	input  logic                      fill_en,
	input  icache_ctrl_pkg::way_t     fill_way,
	input  logic [`ICACHE_ADDR_W-1:0] fill_addr,
	input  logic                      inv_valid,
	input  logic [`ICACHE_ADDR_W-1:0] inv_addr,
	input  logic                      flush,
	output icache_ctrl_pkg::way_t     hit_way
);
	import icache_addr_pkg::*;

	// one valid vector per way, bit per set
	logic [`ICACHE_SETS-1:0] valid_q [`ICACHE_WAYS];
	tag_t tag_q [`ICACHE_WAYS][`ICACHE_SETS];

	index_t lk_index;
	tag_t lk_tag;
	index_t fill_index;
	tag_t fill_tag;
	index_t inv_index;
	tag_t inv_tag;
	logic inv_kills_fill;

	assign lk_index = addr_index(lookup_addr);
	assign lk_tag = addr_tag(lookup_addr);
	assign fill_index = addr_index(fill_addr);
	assign fill_tag = addr_tag(fill_addr);
	assign inv_index = addr_index(inv_addr);
	assign inv_tag = addr_tag(inv_addr);

	// snoop hits the line being filled right now
	assign inv_kills_fill = inv_valid && (inv_index == fill_index) && (inv_tag == fill_tag);

	// all four ways compared in parallel
	always_comb begin
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			hit_way[w] = valid_q[w][lk_index] && (tag_q[w][lk_index] == lk_tag);
		end
	end

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				valid_q[w] <= '0;
			end
		end else begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				// victim way is overwritten, so old contents go away either way
				if (fill_en && fill_way[w]) begin
					valid_q[w][fill_index] <= !inv_kills_fill;
				end
				// snoop clears every way holding the tag
				// a fill into the same slot already settled its valid bit
				if (inv_valid && (tag_q[w][inv_index] == inv_tag)
						&& !(fill_en && fill_way[w] && (fill_index == inv_index))) begin
					valid_q[w][inv_index] <= 1'b0;
				end
			end
		end
	end

	// tag written with the fill beat
	always_ff @(posedge clk) begin
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (fill_en && fill_way[w]) begin
				tag_q[w][fill_index] <= fill_tag;
			end
		end
	end

	// fills only follow a miss, so no tag lands in two ways of a set
	a_hit_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(hit_way))
		else $error("icache tag array: multiple ways hit %b", hit_way);

endmodule

//--- verilog/icache_ctrl_pkg.sv
`include "icache_params.svh"

package icache_ctrl_pkg;

	// fetch controller states
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_REFILL_REQ,
		ST_REFILL_WAIT,
		ST_RESP
	} ctrl_state_e;

	// one bit per way, at most one set
	typedef logic [`ICACHE_WAYS-1:0] way_t;

	// victim pointer step, way 3 wraps to way 0
	function automatic way_t rotate_way(input way_t way);
		return {way[`ICACHE_WAYS-2:0], way[`ICACHE_WAYS-1]};
	endfunction

endpackage

//--- verilog/icache_addr_pkg.sv
`include "icache_params.svh"

package icache_addr_pkg;

	typedef logic [`ICACHE_TAG_W-1:0] tag_t;
	typedef logic [`ICACHE_INDEX_W-1:0] index_t;
	// word within a line, byte offset bits dropped
	typedef logic [`ICACHE_OFFSET_W-3:0] word_sel_t;
	// word 0 sits in the low bits
	typedef logic [`ICACHE_LINE_W-1:0] line_t;

	function automatic tag_t addr_tag(input logic [`ICACHE_ADDR_W-1:0] addr);
		return addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
	endfunction

	function automatic index_t addr_index(input logic [`ICACHE_ADDR_W-1:0] addr);
		return addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
	endfunction

	function automatic word_sel_t addr_word(input logic [`ICACHE_ADDR_W-1:0] addr);
		return addr[`ICACHE_OFFSET_W-1:2];
	endfunction

	function automatic logic [31:0] line_word(input line_t line, input word_sel_t sel);
		return line[32 * sel +: 32];
	endfunction

endpackage

//--- verilog/icache_params.svh
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// fetch address width in bits
`define ICACHE_ADDR_W 32

// one line is four 32-bit instructions
`define ICACHE_LINE_W 128

// associativity and depth
`define ICACHE_WAYS 4
`define ICACHE_SETS 64

// address split: tag | index | offset
`define ICACHE_INDEX_W 6
`define ICACHE_TAG_W 22
`define ICACHE_OFFSET_W 4

`endif
